// ==== design/rv_core.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_core (
    input  logic                i_clk,
    input  logic                i_arst_n,
    output rv_pkg::bus_req_t    o_ibus,
    input  logic                i_ibus_ack,
    input  logic [`RV_XLEN-1:0] i_ibus_rdata,
    output rv_pkg::bus_req_t    o_dbus,
    input  logic                i_dbus_ack,
    input  logic [`RV_XLEN-1:0] i_dbus_rdata,
    output rv_pkg::retire_t     o_retire
);

    logic                f_valid;
    logic [`RV_XLEN-1:0] f_instr;
    logic [`RV_XLEN-1:0] f_pc;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic                d_valid;
    rv_pkg::dec_t        d_dec;
    rv_pkg::wr_t         wr;
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    rv_fetch u_fetch (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_retire      (o_retire),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_ibus        (o_ibus),
        .i_ibus_ack    (i_ibus_ack),
        .i_ibus_rdata  (i_ibus_rdata),
        .o_valid       (f_valid),
        .o_instr       (f_instr),
        .o_pc          (f_pc)
    );

    rv_decode u_decode (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_valid   (f_valid),
        .i_instr   (f_instr),
        .i_pc      (f_pc),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .o_valid   (d_valid),
        .o_dec     (d_dec)
    );

    rv_regfile u_regfile (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val),
        .i_wr      (wr)
    );

    rv_execute u_execute (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_valid       (d_valid),
        .i_dec         (d_dec),
        .o_dbus        (o_dbus),
        .i_dbus_ack    (i_dbus_ack),
        .i_dbus_rdata  (i_dbus_rdata),
        .o_wr          (wr),
        .o_retire      (o_retire),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    // decode cannot hand over a new instruction while execute retires one.
    a_strobes_apart: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(d_valid && o_retire.valid))
        else $error("decode strobe in the same cycle as a retire");

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_decode (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_valid,
    input  logic [`RV_XLEN-1:0] i_instr,
    input  logic [`RV_XLEN-1:0] i_pc,
    output logic [4:0]          o_rs1,
    output logic [4:0]          o_rs2,
    input  logic [`RV_XLEN-1:0] i_rs1_val,
    input  logic [`RV_XLEN-1:0] i_rs2_val,
    output logic                o_valid,
    output rv_pkg::dec_t        o_dec
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] b_val;
    rv_pkg::op_e         op;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        op    = rv_pkg::OP_NOP;
        imm   = imm_i;
        b_val = i_rs2_val;
        case (opcode)
            OPC_LUI: begin
                op  = rv_pkg::OP_LUI;
                imm = imm_u;
            end
            OPC_OP_IMM: begin
                // the immediate replaces rs2 so execute sees a register op.
                b_val = imm_i;
                case (funct3)
                    3'b000:  op = rv_pkg::OP_ADD;
                    3'b100:  op = rv_pkg::OP_XOR;
                    3'b110:  op = rv_pkg::OP_OR;
                    3'b111:  op = rv_pkg::OP_AND;
                    default: op = rv_pkg::OP_NOP;
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = rv_pkg::OP_ADD;
                        3'b010:  op = rv_pkg::OP_SLT;
                        3'b100:  op = rv_pkg::OP_XOR;
                        3'b110:  op = rv_pkg::OP_OR;
                        3'b111:  op = rv_pkg::OP_AND;
                        default: op = rv_pkg::OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = rv_pkg::OP_SUB;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    op = rv_pkg::OP_LW;
                end
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == 3'b010) begin
                    op = rv_pkg::OP_SW;
                end
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    op = rv_pkg::OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = rv_pkg::OP_BNE;
                end
            end
            OPC_JAL: begin
                op  = rv_pkg::OP_JAL;
                imm = imm_j;
            end
            default: op = rv_pkg::OP_NOP;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_dec <= '{op: op, rd: i_instr[11:7], rs1_val: i_rs1_val, rs2_val: b_val,
                       imm: imm, pc: i_pc};
        end
    end

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_execute (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_valid,
    input  rv_pkg::dec_t        i_dec,
    output rv_pkg::bus_req_t    o_dbus,
    input  logic                i_dbus_ack,
    input  logic [`RV_XLEN-1:0] i_dbus_rdata,
    output rv_pkg::wr_t         o_wr,
    output rv_pkg::retire_t     o_retire,
    output logic                o_redirect,
    output logic [`RV_XLEN-1:0] o_redirect_pc
);

    logic                is_mem;
    logic                taken;
    logic                alu_we;
    logic [`RV_XLEN-1:0] alu_res;
    logic                mem_done;
    logic                dbus_req;
    logic                dbus_we;
    logic [`RV_XLEN-1:0] dbus_addr;
    logic [`RV_XLEN-1:0] dbus_wdata;
    logic                wr_en;
    logic [4:0]          wr_rd;
    logic [`RV_XLEN-1:0] wr_data;
    logic                retire_valid;
    logic [`RV_XLEN-1:0] retire_pc;

    assign is_mem   = (i_dec.op == rv_pkg::OP_LW) || (i_dec.op == rv_pkg::OP_SW);
    assign mem_done = dbus_req & i_dbus_ack;

    always_comb begin
        alu_res = '0;
        alu_we  = 1'b1;
        taken   = 1'b0;
        case (i_dec.op)
            rv_pkg::OP_LUI: alu_res = i_dec.imm;
            rv_pkg::OP_ADD: alu_res = i_dec.rs1_val + i_dec.rs2_val;
            rv_pkg::OP_SUB: alu_res = i_dec.rs1_val - i_dec.rs2_val;
            rv_pkg::OP_AND: alu_res = i_dec.rs1_val & i_dec.rs2_val;
            rv_pkg::OP_OR:  alu_res = i_dec.rs1_val | i_dec.rs2_val;
            rv_pkg::OP_XOR: alu_res = i_dec.rs1_val ^ i_dec.rs2_val;
            rv_pkg::OP_SLT: alu_res = {31'b0, $signed(i_dec.rs1_val) < $signed(i_dec.rs2_val)};
            rv_pkg::OP_JAL: begin
                alu_res = i_dec.pc + `RV_XLEN'd4;
                taken   = 1'b1;
            end
            rv_pkg::OP_BEQ: begin
                alu_we = 1'b0;
                taken  = (i_dec.rs1_val == i_dec.rs2_val);
            end
            rv_pkg::OP_BNE: begin
                alu_we = 1'b0;
                taken  = (i_dec.rs1_val != i_dec.rs2_val);
            end
            default: alu_we = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dbus_req     <= 1'b0;
            wr_en        <= 1'b0;
            retire_valid <= 1'b0;
            o_redirect   <= 1'b0;
        end else begin
            wr_en        <= 1'b0;
            retire_valid <= 1'b0;
            o_redirect   <= 1'b0;
            if (mem_done) begin
                dbus_req     <= 1'b0;
                retire_valid <= 1'b1;
                wr_en        <= !dbus_we;
            end else if (i_valid && is_mem) begin
                dbus_req <= 1'b1;
            end else if (i_valid) begin
                retire_valid <= 1'b1;
                wr_en        <= alu_we;
                o_redirect   <= taken;
            end
        end
    end

    // rd and pc are captured at the strobe and held through the bus wait.
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            dbus_we       <= (i_dec.op == rv_pkg::OP_SW);
            dbus_addr     <= i_dec.rs1_val + i_dec.imm;
            dbus_wdata    <= i_dec.rs2_val;
            wr_rd         <= i_dec.rd;
            wr_data       <= alu_res;
            retire_pc     <= i_dec.pc;
            o_redirect_pc <= i_dec.pc + i_dec.imm;
        end else if (mem_done) begin
            wr_data <= i_dbus_rdata;
        end
    end

    assign o_dbus   = '{req: dbus_req, we: dbus_we, addr: dbus_addr, wdata: dbus_wdata,
                        sel: 4'hF};
    assign o_wr     = '{en: wr_en, rd: wr_rd, data: wr_data};
    assign o_retire = '{valid: retire_valid, pc: retire_pc};

    a_no_req_on_alu_retire: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_dbus.req |-> !o_retire.valid)
        else $error("instruction retired while a data request was pending");

    // a full-word select needs a word-aligned address.
    a_word_sel: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_dbus.req |-> o_dbus.addr[1:0] == 2'b00)
        else $error("data request to an address that is not word aligned");

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_fetch (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  rv_pkg::retire_t     i_retire,
    input  logic                i_redirect,
    input  logic [`RV_XLEN-1:0] i_redirect_pc,
    output rv_pkg::bus_req_t    o_ibus,
    input  logic                i_ibus_ack,
    input  logic [`RV_XLEN-1:0] i_ibus_rdata,
    output logic                o_valid,
    output logic [`RV_XLEN-1:0] o_instr,
    output logic [`RV_XLEN-1:0] o_pc
);

    logic                boot;
    logic                ibus_req;
    logic                fetch_done;
    logic [`RV_XLEN-1:0] pc;

    assign fetch_done = ibus_req & i_ibus_ack;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            boot     <= 1'b1;
            ibus_req <= 1'b0;
            o_valid  <= 1'b0;
            pc       <= `RV_RESET_ADDR;
        end else begin
            boot    <= 1'b0;
            o_valid <= fetch_done;
            if (boot) begin
                ibus_req <= 1'b1;
            end else if (fetch_done) begin
                ibus_req <= 1'b0;
            end else if (i_retire.valid) begin
                // the next fetch starts only once the current instruction is gone.
                ibus_req <= 1'b1;
                pc       <= i_redirect ? i_redirect_pc : pc + `RV_XLEN'd4;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch_done) begin
            o_instr <= i_ibus_rdata;
        end
    end

    // pc stays put until retire, so it still names the word sent to decode.
    assign o_pc   = pc;
    assign o_ibus = '{req: ibus_req, we: 1'b0, addr: pc, wdata: '0, sel: 4'hF};

    // a retire that meets a pending fetch would mean two instructions in flight.
    a_single_in_flight: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ibus_req |-> !i_retire.valid)
        else $error("instruction retired while the next fetch was already pending");

endmodule

// ==== design/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// address of the first instruction fetch after reset.
`define RV_RESET_ADDR 32'h0000_0000

// width of the data path, the registers and the bus addresses.
`define RV_XLEN 32

// number of integer registers, x0 included.
`define RV_NREGS 32

`endif

// ==== design/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    // the immediate forms share the register encodings. Decode places the
    // immediate in the second operand for ADDI, ANDI, ORI and XORI.
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LUI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    typedef struct packed {
        op_e                 op;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] pc;
    } dec_t;

    typedef struct packed {
        logic                req;
        logic                we;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic [3:0]          sel;
    } bus_req_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
    } retire_t;

    typedef struct packed {
        logic                en;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wr_t;

endpackage

// ==== design/rv_regfile.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_regfile (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic [4:0]          i_rs1,
    input  logic [4:0]          i_rs2,
    output logic [`RV_XLEN-1:0] o_rs1_val,
    output logic [`RV_XLEN-1:0] o_rs2_val,
    input  rv_pkg::wr_t         i_wr
);

    // x0 has no storage and always reads as zero.
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.en && i_wr.rd != 5'd0) begin
            regs[i_wr.rd] <= i_wr.data;
        end
    end

    assign o_rs1_val = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// ==== design/rv_top_wb.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_top_wb (
    input  logic                i_clk,
    input  logic                i_arst_n,
    output logic [`RV_XLEN-1:0] o_wb_adr,
    output logic [`RV_XLEN-1:0] o_wb_dat,
    input  logic [`RV_XLEN-1:0] i_wb_dat,
    output logic                o_wb_we,
    output logic [3:0]          o_wb_sel,
    output logic                o_wb_stb,
    input  logic                i_wb_ack,
    output logic                o_wb_cyc,
    output rv_pkg::retire_t     o_retire
);

    rv_pkg::bus_req_t ibus;
    rv_pkg::bus_req_t dbus;
    logic             instr_ack;
    logic             data_ack;

    rv_core u_core (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .o_ibus       (ibus),
        .i_ibus_ack   (instr_ack),
        .i_ibus_rdata (i_wb_dat),
        .o_dbus       (dbus),
        .i_dbus_ack   (data_ack),
        .i_dbus_rdata (i_wb_dat),
        .o_retire     (o_retire)
    );

    // a pending data request owns the bus.
    assign data_ack  = i_wb_ack & dbus.req;
    assign instr_ack = i_wb_ack & !dbus.req & ibus.req;

    assign o_wb_adr = dbus.req ? dbus.addr : ibus.addr;
    assign o_wb_dat = dbus.wdata;
    assign o_wb_we  = dbus.req & dbus.we;
    assign o_wb_sel = dbus.req ? dbus.sel : ibus.sel;
    assign o_wb_stb = dbus.req | ibus.req;
    assign o_wb_cyc = dbus.req | ibus.req;

    // every acknowledge from the slave must land on exactly one port.
    a_single_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb_ack |-> instr_ack ^ data_ack)
        else $error("bus acknowledge not steered to exactly one port");

endmodule

// ==== tb/rv_tb.sv ====
`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_tb;

    localparam int unsigned SEED         = 68156;
    localparam int          NINSTR       = 200;
    localparam int          MEM_WORDS    = 2048;
    localparam int          DATA_WORDS   = 16;
    localparam logic [31:0] DATA_BASE    = 32'h0000_1000;
    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_WAIT     = 3;
    localparam int          TIMEOUT      = NINSTR * (5 + 2 * MAX_WAIT) + RESET_CYCLES;

    // the first eleven kinds line up with the random pick in gen_program.
    typedef enum int {
        K_LUI, K_ADDI, K_ANDI, K_ORI, K_XORI,
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_LW, K_SW, K_BEQ, K_BNE, K_JAL
    } kind_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic            clk;
    logic            arst_n;
    logic [31:0]     wb_adr;
    logic [31:0]     wb_dat_w;
    logic [31:0]     wb_dat_r;
    logic            wb_we;
    logic [3:0]      wb_sel;
    logic            wb_stb;
    logic            wb_ack;
    logic            wb_cyc;
    rv_pkg::retire_t retire;
    rv_pkg::retire_t want;

    kind_e       prog_kind [NINSTR];
    logic [4:0]  prog_rd   [NINSTR];
    logic [4:0]  prog_rs1  [NINSTR];
    logic [4:0]  prog_rs2  [NINSTR];
    logic [31:0] prog_imm  [NINSTR];
    logic [31:0] image     [MEM_WORDS];
    logic [31:0] exp_pc    [$];
    store_t      exp_store [$];
    int          n_emit;
    int          cycles     = 0;
    logic        ack_seen   = 1'b0;
    logic        first_done = 1'b0;
    logic        run_done   = 1'b0;

    rv_top_wb u_dut (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .o_wb_adr (wb_adr),
        .o_wb_dat (wb_dat_w),
        .i_wb_dat (wb_dat_r),
        .o_wb_we  (wb_we),
        .o_wb_sel (wb_sel),
        .o_wb_stb (wb_stb),
        .i_wb_ack (wb_ack),
        .o_wb_cyc (wb_cyc),
        .o_retire (retire)
    );

    rv_tb_mem #(.WORDS(MEM_WORDS)) u_mem (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_adr    (wb_adr),
        .i_dat    (wb_dat_w),
        .o_dat    (wb_dat_r),
        .i_we     (wb_we),
        .i_sel    (wb_sel),
        .i_stb    (wb_stb),
        .i_cyc    (wb_cyc),
        .o_ack    (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] fill_word(input int w);
        logic [31:0] byte_addr;
        byte_addr = 32'(w) << 2;
        // an odd multiplier keeps every address bit visible in the word.
        return (byte_addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] w;
        case (k)
            K_LUI:  w = {imm[31:12], rd, 7'b0110111};
            K_ADDI: w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_XORI: w = {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            K_ORI:  w = {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            K_ANDI: w = {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            K_ADD:  w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SLT:  w = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_XOR:  w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_OR:   w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_AND:  w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_LW:   w = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:   w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_BEQ:  w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:  w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            K_JAL:  w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic emit(input kind_e k, input int rd, input int rs1, input int rs2,
            input logic [31:0] imm);
        prog_kind[n_emit] = k;
        prog_rd[n_emit]   = 5'(rd);
        prog_rs1[n_emit]  = 5'(rs1);
        prog_rs2[n_emit]  = 5'(rs2);
        prog_imm[n_emit]  = imm;
        image[n_emit]     = encode(k, 5'(rd), 5'(rs1), 5'(rs2), imm);
        n_emit++;
    endtask

    task automatic gen_program();
        int          pick;
        int          rd;
        int          rs1;
        int          rs2;
        int          span;
        logic [11:0] r12;
        logic [31:0] imm;
        for (int w = 0; w < MEM_WORDS; w++) begin
            image[w] = fill_word(w);
        end
        n_emit = 0;
        // x8 holds the data window base and is never a random destination.
        emit(K_LUI, 8, 0, 0, DATA_BASE);
        while (n_emit < NINSTR - 1) begin
            pick = $urandom_range(15, 0);
            rd   = $urandom_range(7, 1);
            rs1  = $urandom_range(7, 0);
            rs2  = ($urandom_range(3, 0) == 0) ? rs1 : $urandom_range(7, 0);
            r12  = 12'($urandom_range(4095, 0));
            imm  = {{20{r12[11]}}, r12};
            span = (NINSTR - 1 - n_emit > 8) ? 8 : NINSTR - 1 - n_emit;
            if (pick == 0) begin
                emit(K_LUI, rd, 0, 0, $urandom() & 32'hFFFF_F000);
            end else if (pick <= 10) begin
                emit(kind_e'(pick), rd, rs1, rs2, imm);
            end else if (pick == 11 && span >= 2) begin
                emit(K_LW, rd, 8, 0, 32'(4 * $urandom_range(DATA_WORDS - 1, 0)));
                emit(K_SW, 0, 8, rd, 32'(4 * $urandom_range(DATA_WORDS - 1, 0)));
            end else if (pick == 12) begin
                emit(K_SW, 0, 8, rs2, 32'(4 * $urandom_range(DATA_WORDS - 1, 0)));
            end else if (pick == 13) begin
                emit($urandom_range(1, 0) ? K_BEQ : K_BNE, 0, rs1, rs2,
                     32'(4 * $urandom_range(span, 1)));
            end else if (pick == 14) begin
                emit(K_JAL, rd, 0, 0, 32'(4 * $urandom_range(span, 1)));
            end else if (span >= 2) begin
                // a write to x0 must leave zero behind for the store that follows.
                emit(K_ADDI, 0, rs1, 0, imm);
                emit(K_SW, 0, 8, 0, 32'(4 * $urandom_range(DATA_WORDS - 1, 0)));
            end else begin
                emit(K_ADDI, rd, rs1, 0, imm);
            end
        end
        emit(K_JAL, 0, 0, 0, 32'd0);
    endtask

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] mem  [MEM_WORDS];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        int          idx;
        int          next;
        foreach (regs[r]) begin
            regs[r] = '0;
        end
        foreach (mem[w]) begin
            mem[w] = image[w];
        end
        idx = 0;
        while (idx != NINSTR - 1) begin
            exp_pc.push_back(32'(idx) * 4);
            a    = regs[prog_rs1[idx]];
            b    = regs[prog_rs2[idx]];
            addr = a + prog_imm[idx];
            next = idx + 1;
            wr   = 1'b1;
            res  = '0;
            case (prog_kind[idx])
                K_LUI:  res = prog_imm[idx];
                K_ADDI: res = a + prog_imm[idx];
                K_ANDI: res = a & prog_imm[idx];
                K_ORI:  res = a | prog_imm[idx];
                K_XORI: res = a ^ prog_imm[idx];
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_LW:   res = mem[addr[12:2]];
                K_SW: begin
                    wr = 1'b0;
                    mem[addr[12:2]] = b;
                    exp_store.push_back('{addr: addr, data: b});
                end
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (prog_kind[idx] == K_BEQ)) begin
                        next = idx + int'(prog_imm[idx] >> 2);
                    end
                end
                default: begin
                    res  = 32'(idx) * 4 + 4;
                    next = idx + int'(prog_imm[idx] >> 2);
                end
            endcase
            if (wr && prog_rd[idx] != 5'd0) begin
                regs[prog_rd[idx]] = res;
            end
            idx = next;
        end
        exp_pc.push_back(32'(idx) * 4);
    endtask

    task automatic compare_fetch(input logic [31:0] adr, input logic we, input logic [3:0] sel);
        if (adr !== `RV_RESET_ADDR) begin
            stop_run($sformatf("ERR o_wb_adr got %08h expected %08h", adr, `RV_RESET_ADDR));
        end else if (we !== 1'b0) begin
            stop_run($sformatf("ERR o_wb_we got %0h expected 0", we));
        end else if (sel !== 4'hF) begin
            stop_run($sformatf("ERR o_wb_sel got %0h expected f", sel));
        end
    endtask

    task automatic compare_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR o_retire.pc got %08h expected %08h", got.pc, exp.pc));
        end
    endtask

    task automatic compare_store(input logic [31:0] adr, input logic [31:0] dat,
            input logic [3:0] sel);
        store_t exp;
        if (exp_store.size() == 0) begin
            stop_run($sformatf("the core wrote to address %08h after the last expected store", adr));
        end else begin
            exp = exp_store.pop_front();
            if (adr !== exp.addr) begin
                stop_run($sformatf("ERR o_wb_adr got %08h expected %08h", adr, exp.addr));
            end else if (dat !== exp.data) begin
                stop_run($sformatf("ERR o_wb_dat got %08h expected %08h", dat, exp.data));
            end else if (sel !== 4'hF) begin
                stop_run($sformatf("ERR o_wb_sel got %0h expected f", sel));
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            stop_run($sformatf("timeout, the final pc did not retire within %0d cycles", TIMEOUT));
        end else if (arst_n && !run_done) begin
            // the core has no request in the cycle after an acknowledge or while it retires.
            if ((ack_seen || retire.valid) && (wb_stb || wb_cyc)) begin
                stop_run("the bus strobe stayed high while the core had no request pending");
            end
            ack_seen = wb_stb && wb_ack;
            if (wb_stb && !first_done) begin
                compare_fetch(wb_adr, wb_we, wb_sel);
                first_done = 1'b1;
            end
            if (wb_stb && wb_ack && wb_we) begin
                compare_store(wb_adr, wb_dat_w, wb_sel);
            end
            if (retire.valid) begin
                if (exp_pc.size() == 0) begin
                    stop_run("the core retired an instruction past the end of the program");
                end else begin
                    want = '{valid: 1'b1, pc: exp_pc.pop_front()};
                    compare_retire(retire, want);
                    run_done = (exp_pc.size() == 0);
                end
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        void'($urandom(SEED));
        gen_program();
        run_model();
        for (int w = 0; w < MEM_WORDS; w++) begin
            u_mem.mem[w] = image[w];
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        wait (run_done);
        if (exp_store.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_run($sformatf("%0d expected stores never reached the bus", exp_store.size()));
        end
    end

endmodule

// ==== tb/rv_tb_mem.sv ====
`timescale 1ns/10ps

module rv_tb_mem #(
    parameter int WORDS = 2048
) (
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    output logic [31:0] o_dat,
    input  logic        i_we,
    input  logic [3:0]  i_sel,
    input  logic        i_stb,
    input  logic        i_cyc,
    output logic        o_ack
);

    localparam int AW = $clog2(WORDS);

    logic [31:0]   mem [WORDS];
    logic          busy;
    logic [1:0]    wait_cnt;
    logic [AW-1:0] idx;

    assign idx = i_adr[AW+1:2];

    // the slave runs on the falling edge, so ack and read data are settled
    // half a cycle before the core samples them. Each access takes one
    // registered cycle plus 0 to 3 random wait states.
    always @(negedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack    <= 1'b0;
            o_dat    <= '0;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (o_ack) begin
            o_ack <= 1'b0;
            busy  <= 1'b0;
        end else if (i_cyc && i_stb) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= 2'($urandom_range(3, 0));
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                o_ack <= 1'b1;
                if (i_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_sel[b]) begin
                            mem[idx][8*b +: 8] <= i_dat[8*b +: 8];
                        end
                    end
                end else begin
                    o_dat <= mem[idx];
                end
            end
        end
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
design/rv_top_wb.sv
tb/rv_tb_mem.sv
tb/rv_tb.sv
